/* all.f */
+incdir+src
src/cache_pkg.sv
src/cache_controller.sv
src/cache_tag_store.sv
src/cache_data_array.sv
src/cache_byte_align.sv
src/cache_top.sv
verification/cache_asserts.sv
verification/cache_checker.sv
verification/cache_tb.sv

/* src/cache_byte_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_byte_align (
   input  cache_pkg::offset_t    offset,
   input  logic [3:0]            size,
   input  cache_pkg::line_t      data_write,
   input  cache_pkg::line_t      line_out,
   output cache_pkg::line_t      write_line,
   output cache_pkg::byte_mask_t write_mask,
   output cache_pkg::line_t      data_read
);

   import cache_pkg::*;

   byte_mask_t base_mask;
   byte_mask_t shifted_mask;
   logic [`CACHE_OFFSET_W+2:0] bit_shift;

   // size low bits set, 1 2 4 or 8 bytes
   assign base_mask = byte_mask_t'((32'd1 << size) - 32'd1);

   // bytes past byte 15 fall off the top
   assign shifted_mask = base_mask << offset;

   // 4'hF is the full line, offset ignored
   always_comb
   begin
      if (size == 4'hF)
         write_mask = '1;
      else
         write_mask = shifted_mask;
   end

   // byte offset as bit count
   assign bit_shift = {offset, 3'b000};

   // processor byte 0 lands at the addressed byte
   assign write_line = data_write << bit_shift;

   // addressed byte back to bits 7:0, zeros shifted in
   assign data_read = line_out >> bit_shift;

endmodule

`default_nettype wire

/* src/cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_controller (
   input  logic                     CLK,
   input  logic                     reset,
   input  logic                     enable,
   input  cache_pkg::cache_op_t     op,
   input  logic [`CACHE_ADDR_W-1:0] address,
   input  logic                     hit,
   input  logic                     conflict,
   input  cache_pkg::tag_t          victim_tag,
   input  logic                     bus_r,
   output logic                     ready,
   output logic                     bus_en,
   output logic                     bus_wr,
   output logic [`CACHE_ADDR_W-1:0] bus_addr,
   output logic                     fill,
   output logic                     store,
   output logic                     tag_write
);

   import cache_pkg::*;

   cache_state_t state;
   cache_state_t state_next;
   tag_t         req_tag;
   index_t       req_index;
   logic         in_evict;
   logic         in_miss;

   assign req_tag   = address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign req_index = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   always_ff @(posedge CLK)
   begin
      if (reset)
         state <= st_idle;
      else
         state <= state_next;
   end

   // lookup states branch on the tag store result
   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
            if (enable)
               state_next = (op == op_write) ? st_wr : st_rd;
         st_rd:
            if (hit)
               state_next = st_rd_hit;
            else if (conflict)
               state_next = st_rd_evict;
            else
               state_next = st_rd_miss;
         st_wr:
            if (hit)
               state_next = st_wr_hit;
            else if (conflict)
               state_next = st_wr_evict;
            else
               state_next = st_wr_miss;
         // write-back done, fetch the new line next
         st_rd_evict:
            if (bus_r)
               state_next = st_rd_miss;
         st_wr_evict:
            if (bus_r)
               state_next = st_wr_miss;
         // fill lands at the same edge, so the hit state sees a valid line
         st_rd_miss:
            if (bus_r)
               state_next = st_rd_hit;
         st_wr_miss:
            if (bus_r)
               state_next = st_wr_hit;
         default:
            state_next = st_idle;
      endcase
   end

   assign in_evict = (state == st_rd_evict) || (state == st_wr_evict);
   assign in_miss  = (state == st_rd_miss) || (state == st_wr_miss);

   // bus held busy through write-back and fill
   assign bus_en    = in_evict || in_miss;
   assign bus_wr    = in_evict;
   assign fill      = in_miss && bus_r;
   assign tag_write = in_miss && bus_r;
   // merge processor bytes once the line is present
   assign store     = (state == st_wr_hit);

   // victim line on write-back, requested line on fill
   assign bus_addr = in_evict ? {victim_tag, req_index, `CACHE_OFFSET_W'(0)}
                              : {req_tag, req_index, `CACHE_OFFSET_W'(0)};

   // one cycle pulse, after the store edge on writes
   always_ff @(posedge CLK)
   begin
      if (reset)
         ready <= 1'b0;
      else
         ready <= (state == st_rd_hit) || (state == st_wr_hit);
   end

endmodule

`default_nettype wire

/* src/cache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_data_array (
   input  logic                  CLK,
   input  cache_pkg::index_t     index,
   input  logic                  fill,
   input  logic                  store,
   input  cache_pkg::line_t      bus_read,
   input  cache_pkg::line_t      write_line,
   input  cache_pkg::byte_mask_t write_mask,
   output cache_pkg::line_t      line_out
);

   import cache_pkg::*;

   line_t      lines [`CACHE_LINES];
   line_t      din;
   byte_mask_t byte_wen;

   // fill takes the whole bus line, store only the masked bytes
   always_comb
   begin
      if (fill)
      begin
         din      = bus_read;
         byte_wen = '1;
      end
      else
      begin
         din      = write_line;
         byte_wen = store ? write_mask : '0;
      end
   end

   // per byte write enables
   always_ff @(posedge CLK)
   begin
      for (int b = 0; b < `CACHE_LINE_BYTES; b++)
         if (byte_wen[b])
            lines[index][b*8 +: 8] <= din[b*8 +: 8];
   end

   // async read, feeds aligner and bus
   assign line_out = lines[index];

endmodule

`default_nettype wire

/* src/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// processor and bus address
`define CACHE_ADDR_W 16

// address fields, tag on top, byte offset at the bottom
`define CACHE_TAG_W 7
`define CACHE_INDEX_W 5
`define CACHE_OFFSET_W 4

// line geometry
`define CACHE_LINE_W 128
`define CACHE_LINE_BYTES 16

// direct mapped, one line per index
`define CACHE_LINES 32

`endif

/* src/cache_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

   // controller states, read and write paths kept apart
   typedef enum logic [3:0] {
      st_idle,
      st_rd,
      st_rd_hit,
      st_rd_miss,
      st_rd_evict,
      st_wr,
      st_wr_hit,
      st_wr_miss,
      st_wr_evict
   } cache_state_t;

   // processor access type
   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } cache_op_t;

   // address fields and line storage
   typedef logic [`CACHE_TAG_W-1:0]      tag_t;
   typedef logic [`CACHE_INDEX_W-1:0]    index_t;
   typedef logic [`CACHE_OFFSET_W-1:0]   offset_t;
   typedef logic [`CACHE_LINE_W-1:0]     line_t;
   typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;

endpackage

`default_nettype wire

/* src/cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tag_store (
   input  logic                     CLK,
   input  logic                     reset,
   input  logic [`CACHE_ADDR_W-1:0] address,
   input  logic                     tag_write,
   output logic                     hit,
   output logic                     conflict,
   output cache_pkg::tag_t          victim_tag
);

   import cache_pkg::*;

   tag_t                  tags [`CACHE_LINES];
   logic [`CACHE_LINES-1:0] valid;
   tag_t                  req_tag;
   index_t                req_index;
   logic                  tag_match;

   assign req_tag   = address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign req_index = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   // valid bits only ever set, reset is the sole clear
   always_ff @(posedge CLK)
   begin
      if (reset)
         valid <= '0;
      else if (tag_write)
         valid[req_index] <= 1'b1;
   end

   // tag recorded alongside the fill
   always_ff @(posedge CLK)
   begin
      if (tag_write)
         tags[req_index] <= req_tag;
   end

   // stored tag also forms the write-back address
   assign victim_tag = tags[req_index];
   assign tag_match  = (victim_tag == req_tag);

   // invalid line is neither, plain miss
   assign hit      = valid[req_index] && tag_match;
   assign conflict = valid[req_index] && !tag_match;

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_top (
   input  logic                     CLK,
   input  logic                     reset,
   input  logic                     enable,
   input  cache_pkg::cache_op_t     op,
   input  logic [`CACHE_ADDR_W-1:0] address,
   input  logic [3:0]               size,
   input  cache_pkg::line_t         data_write,
   output cache_pkg::line_t         data_read,
   output logic                     ready,
   output logic                     bus_en,
   output logic                     bus_wr,
   output logic [`CACHE_ADDR_W-1:0] bus_addr,
   output cache_pkg::line_t         bus_write,
   input  logic                     bus_r,
   input  cache_pkg::line_t         bus_read
);

   // controller strobes
   logic                         fill;
   logic                         store;
   logic                         tag_write;

   // tag store results
   logic                         hit;
   logic                         conflict;
   logic [`CACHE_TAG_W-1:0]      victim_tag;

   // datapath between aligner and array
   logic [`CACHE_LINE_W-1:0]     line_out;
   logic [`CACHE_LINE_W-1:0]     write_line;
   logic [`CACHE_LINE_BYTES-1:0] write_mask;

   cache_controller u_controller (
      .CLK        (CLK),
      .reset      (reset),
      .enable     (enable),
      .op         (op),
      .address    (address),
      .hit        (hit),
      .conflict   (conflict),
      .victim_tag (victim_tag),
      .bus_r      (bus_r),
      .ready      (ready),
      .bus_en     (bus_en),
      .bus_wr     (bus_wr),
      .bus_addr   (bus_addr),
      .fill       (fill),
      .store      (store),
      .tag_write  (tag_write)
   );

   cache_tag_store u_tag_store (
      .CLK        (CLK),
      .reset      (reset),
      .address    (address),
      .tag_write  (tag_write),
      .hit        (hit),
      .conflict   (conflict),
      .victim_tag (victim_tag)
   );

   // stored line goes out unchanged on write-back
   cache_data_array u_data_array (
      .CLK        (CLK),
      .index      (address[`CACHE_OFFSET_W +: `CACHE_INDEX_W]),
      .fill       (fill),
      .store      (store),
      .bus_read   (bus_read),
      .write_line (write_line),
      .write_mask (write_mask),
      .line_out   (bus_write)
   );

   assign line_out = bus_write;

   cache_byte_align u_byte_align (
      .offset     (address[`CACHE_OFFSET_W-1:0]),
      .size       (size),
      .data_write (data_write),
      .line_out   (line_out),
      .write_line (write_line),
      .write_mask (write_mask),
      .data_read  (data_read)
   );

endmodule

`default_nettype wire

/* verification/cache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_asserts (
   input logic                     CLK,
   input logic                     reset,
   input logic                     ready,
   input logic                     bus_en,
   input logic                     bus_wr,
   input logic                     bus_r,
   input logic [`CACHE_ADDR_W-1:0] bus_addr
);

   int fail_count;

   initial
      fail_count = 0;

   // ready is a single cycle pulse
   ready_pulse: assert property (@(posedge CLK) disable iff (reset) ready |=> !ready)
   else
   begin
      $error("ready stayed high longer than one cycle");
      fail_count++;
   end

   // request and its address stay put until the memory answers
   bus_held: assert property (@(posedge CLK) disable iff (reset)
      bus_en && !bus_r |=> bus_en && $stable(bus_wr) && $stable(bus_addr))
   else
   begin
      $error("bus request changed before bus_r");
      fail_count++;
   end

   // write-back answered, fill request follows
   fill_after_wb: assert property (@(posedge CLK) disable iff (reset)
      bus_wr && bus_r |=> bus_en && !bus_wr)
   else
   begin
      $error("no fill request after the write-back");
      fail_count++;
   end

endmodule

bind cache_controller cache_asserts u_asserts (
   .CLK      (CLK),
   .reset    (reset),
   .ready    (ready),
   .bus_en   (bus_en),
   .bus_wr   (bus_wr),
   .bus_r    (bus_r),
   .bus_addr (bus_addr)
);

`default_nettype wire

/* verification/cache_cases.txt */
# name op addr size write_data expected_read, all hex, byte 0 rightmost
# op 0 reads and 1 writes, size is a byte count with F for the whole line
rd_cold      0 0120 1 00000000000000000000000000000000 00000000000000000000000000000000
rd_hit       0 0125 1 00000000000000000000000000000000 00000000000000000000000000000000
wr_b1        1 0123 1 000000000000000000000000000000AA 00000000000000000000000000000000
wr_b2        1 0126 2 0000000000000000000000000000BBCC 00000000000000000000000000000000
wr_b4        1 0128 4 00000000000000000000000044332211 00000000000000000000000000000000
wr_b8_edge   1 012E 8 00000000000000008877665544332211 00000000000000000000000000000000
rd_line      0 0120 1 00000000000000000000000000000000 2211000044332211BBCC0000AA000000
rd_off6      0 0126 1 00000000000000000000000000000000 0000000000002211000044332211BBCC
rd_next      0 0130 1 00000000000000000000000000000000 00000000000000000000000000000000
wr_full      1 0340 F 0F0E0D0C0B0A09080706050403020100 00000000000000000000000000000000
rd_full      0 0344 1 00000000000000000000000000000000 000000000F0E0D0C0B0A090807060504
rd_evict     0 1340 1 00000000000000000000000000000000 00000000000000000000000000000000
wr_merge     1 0343 1 00000000000000000000000000000077 00000000000000000000000000000000
rd_merged    0 0340 1 00000000000000000000000000000000 0F0E0D0C0B0A09080706050477020100
wr_miss_b2   1 0552 2 00000000000000000000000000005A5B 00000000000000000000000000000000
rd_off1      0 0551 1 00000000000000000000000000000000 000000000000000000000000005A5B00
wr_b8        1 0550 8 00000000000000001122334455667788 00000000000000000000000000000000
rd_b8        0 0550 1 00000000000000000000000000000000 00000000000000001122334455667788
rd_evict2    0 7F20 1 00000000000000000000000000000000 00000000000000000000000000000000
rd_back      0 0120 1 00000000000000000000000000000000 2211000044332211BBCC0000AA000000

/* verification/cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_checker (
   input  logic                     CLK,
   input  logic                     reset,
   input  logic                     enable,
   input  cache_pkg::cache_op_t     op,
   input  logic [`CACHE_ADDR_W-1:0] address,
   input  logic [3:0]               size,
   input  cache_pkg::line_t         data_write,
   input  cache_pkg::line_t         data_read,
   input  logic                     ready,
   input  logic                     bus_en,
   input  logic                     bus_wr,
   input  logic [`CACHE_ADDR_W-1:0] bus_addr,
   input  cache_pkg::line_t         bus_write,
   input  logic                     bus_r,
   input  cache_pkg::line_t         bus_read,
   input  logic [127:0]             case_name,
   input  cache_pkg::line_t         case_exp,
   output int                       error_count
);

   import cache_pkg::*;

   // processor view of memory, byte per address
   logic [7:0]              shadow [1 << `CACHE_ADDR_W];
   // which tag each index should hold
   tag_t                    resident_tag [`CACHE_LINES];
   logic [`CACHE_LINES-1:0] resident_valid;
   logic                    busy;
   logic                    bus_used;
   logic                    start_hit;
   int                      cycles;
   int                      reset_edges;

   initial
   begin
      error_count    = 0;
      reset_edges    = 0;
      busy           = 1'b0;
      resident_valid = '0;
      for (int i = 0; i < (1 << `CACHE_ADDR_W); i++)
         shadow[i] = 8'h00;
   end

   function automatic line_t shadow_line(input logic [15:0] base);
      line_t l;
      for (int b = 0; b < 16; b++)
         l[b*8 +: 8] = shadow[base + b];
      return l;
   endfunction

   // addressed byte first, zeros past the line end
   function automatic line_t expected_read(input logic [15:0] a);
      line_t       l;
      logic [15:0] base;
      int          off;
      l    = '0;
      base = {a[15:4], 4'h0};
      off  = a[3:0];
      for (int k = 0; k + off < 16; k++)
         l[k*8 +: 8] = shadow[base + off + k];
      return l;
   endfunction

   // size bytes from the offset, cut at byte 15, F covers the line
   task automatic apply_write(input logic [15:0] a, input logic [3:0] sz, input line_t d);
      logic [15:0] base;
      int          off;
      base = {a[15:4], 4'h0};
      off  = a[3:0];
      for (int b = 0; b < 16; b++)
         if (sz == 4'hF || (b >= off && b < off + sz))
            shadow[base + b] = (b >= off) ? d[(b-off)*8 +: 8] : 8'h00;
   endtask

   task automatic report_value(input string what, input line_t exp, input line_t act);
      $display("Fail %0s %0s: expected %h actual %h", case_name, what, exp, act);
      error_count++;
   endtask

   task automatic report_addr(input string what, input logic [15:0] exp, input logic [15:0] act);
      $display("Fail %0s %0s: expected %h actual %h", case_name, what, exp, act);
      error_count++;
   endtask

   task automatic report_other(input string what);
      $display("%0s, at case %0s", what, case_name);
      error_count++;
   endtask

   always @(posedge CLK)
   begin : watch
      logic [15:0] exp_addr;
      index_t      idx;
      tag_t        tag;
      idx = address[8:4];
      tag = address[15:9];
      if (reset)
      begin
         // outputs are unknown before the first reset edge
         if (reset_edges > 0 && (ready !== 1'b0 || bus_en !== 1'b0 || bus_wr !== 1'b0))
            report_other("ready or a bus request was active during reset");
         reset_edges++;
         busy           = 1'b0;
         resident_valid = '0;
      end
      else
      begin
         if (!busy && enable === 1'b1)
         begin
            busy      = 1'b1;
            cycles    = 0;
            bus_used  = 1'b0;
            start_hit = resident_valid[idx] && resident_tag[idx] == tag;
         end
         else if (busy)
            cycles++;

         if (!busy && (ready !== 1'b0 || bus_en !== 1'b0 || bus_wr !== 1'b0))
            report_other("ready or a bus request was active with no access pending");

         // one bus response completes here
         if (busy && bus_en === 1'b1 && bus_r === 1'b1)
         begin
            bus_used = 1'b1;
            if (bus_wr === 1'b1)
            begin
               if (!resident_valid[idx] || resident_tag[idx] == tag)
                  report_other("write-back issued with no conflicting line cached");
               exp_addr = {resident_tag[idx], idx, 4'h0};
               if (bus_addr !== exp_addr)
                  report_addr("write-back address", exp_addr, bus_addr);
               if (bus_write !== shadow_line(exp_addr))
                  report_value("write-back data", shadow_line(exp_addr), bus_write);
            end
            else
            begin
               exp_addr = {tag, idx, 4'h0};
               if (bus_addr !== exp_addr)
                  report_addr("fill address", exp_addr, bus_addr);
               if (bus_read !== shadow_line(exp_addr))
                  report_value("fill data", shadow_line(exp_addr), bus_read);
               resident_tag[idx]   = tag;
               resident_valid[idx] = 1'b1;
            end
         end

         if (busy && ready === 1'b1)
         begin
            if (start_hit && bus_used)
               report_other("bus traffic on an access that should hit");
            if (!start_hit && !bus_used)
               report_other("access that should miss finished without a fill");
            // ready rises two cycles after enable, seen at the third edge
            if (!bus_used && cycles != 3)
               report_other("hit did not answer two cycles after enable");
            if (op == op_write)
               apply_write(address, size, data_write);
            else
            begin
               if (data_read !== case_exp)
                  report_value("read data vs case file", case_exp, data_read);
               if (data_read !== expected_read(address))
                  report_value("read data vs shadow", expected_read(address), data_read);
            end
            busy = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* verification/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tb;

   import cache_pkg::*;

   // cycles allowed from enable to ready, covers write-back plus fill
   localparam int READY_TIMEOUT = 64;

   logic                     CLK;
   logic                     reset;
   logic                     enable;
   cache_op_t                op;
   logic [`CACHE_ADDR_W-1:0] address;
   logic [3:0]               size;
   line_t                    data_write;
   line_t                    data_read;
   logic                     ready;
   logic                     bus_en;
   logic                     bus_wr;
   logic [`CACHE_ADDR_W-1:0] bus_addr;
   line_t                    bus_write;
   logic                     bus_r;
   line_t                    bus_read;

   // current case, handed to the checker
   logic [127:0]             case_name;
   line_t                    case_exp;

   int                       checker_errors;
   int                       tb_errors;
   int                       cases_run;
   logic                     timed_out;
   logic [31:0]              lfsr;

   // backing memory, one entry per 16 byte line
   line_t                    mem [4096];

   cache_top dut (
      .CLK        (CLK),
      .reset      (reset),
      .enable     (enable),
      .op         (op),
      .address    (address),
      .size       (size),
      .data_write (data_write),
      .data_read  (data_read),
      .ready      (ready),
      .bus_en     (bus_en),
      .bus_wr     (bus_wr),
      .bus_addr   (bus_addr),
      .bus_write  (bus_write),
      .bus_r      (bus_r),
      .bus_read   (bus_read)
   );

   cache_checker u_checker (
      .CLK         (CLK),
      .reset       (reset),
      .enable      (enable),
      .op          (op),
      .address     (address),
      .size        (size),
      .data_write  (data_write),
      .data_read   (data_read),
      .ready       (ready),
      .bus_en      (bus_en),
      .bus_wr      (bus_wr),
      .bus_addr    (bus_addr),
      .bus_write   (bus_write),
      .bus_r       (bus_r),
      .bus_read    (bus_read),
      .case_name   (case_name),
      .case_exp    (case_exp),
      .error_count (checker_errors)
   );

   always #50 CLK = ~CLK;

   // galois step, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ 32'h80200003;
      else
         return state >> 1;
   endfunction

   // memory answers each request after 1 to 4 cycles
   initial
   begin : bus_memory
      logic [1:0] lat_bits;
      int         lat;
      for (int i = 0; i < 4096; i++)
         mem[i] = '0;
      forever
      begin
         @(negedge CLK);
         if (!reset && bus_en === 1'b1)
         begin
            lfsr = lfsr_next(lfsr);
            lat_bits[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            lat_bits[1] = lfsr[0];
            lat = int'(lat_bits) + 1;
            repeat (lat - 1) @(negedge CLK);
            bus_read = mem[bus_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]];
            // write-back lands in memory as the response goes out
            if (bus_wr === 1'b1)
               mem[bus_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]] = bus_write;
            bus_r = 1'b1;
            @(negedge CLK);
            bus_r = 1'b0;
         end
      end
   end

   // one processor access, inputs held until ready
   task automatic run_access(input logic [127:0] name, input cache_op_t o,
                             input logic [15:0] a, input logic [3:0] sz,
                             input line_t wd, input line_t ex);
      int waited;
      @(negedge CLK);
      case_name  = name;
      case_exp   = ex;
      op         = o;
      address    = a;
      size       = sz;
      data_write = wd;
      enable     = 1'b1;
      @(negedge CLK);
      enable = 1'b0;
      waited = 0;
      while (ready !== 1'b1 && waited < READY_TIMEOUT)
      begin
         @(negedge CLK);
         waited++;
      end
      if (ready !== 1'b1)
      begin
         $display("timeout: case %0s got no ready within %0d cycles", name, READY_TIMEOUT);
         tb_errors++;
         timed_out = 1'b1;
      end
   endtask

   initial
   begin : main
      int           fd;
      int           n;
      int           fields;
      int           opv;
      int           assert_fails;
      logic [1023:0] text;
      logic [127:0] name;
      logic [15:0]  a;
      logic [3:0]   sz;
      line_t        wd;
      line_t        ex;

      CLK        = 1'b0;
      reset      = 1'b1;
      enable     = 1'b0;
      op         = op_read;
      address    = '0;
      size       = 4'h1;
      data_write = '0;
      bus_r      = 1'b0;
      bus_read   = '0;
      case_name  = '0;
      case_exp   = '0;
      tb_errors  = 0;
      cases_run  = 0;
      timed_out  = 1'b0;
      lfsr       = 32'h38c7d7bf;

      repeat (16) @(posedge CLK);
      @(negedge CLK);
      reset = 1'b0;
      // a few idle cycles so the checker sees a quiet bus after reset
      repeat (3) @(negedge CLK);

      fd = $fopen("verification/cache_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the case file verification/cache_cases.txt");
         tb_errors++;
      end
      else
      begin
         while (!$feof(fd) && !timed_out)
         begin
            text = '0;
            n = $fgets(text, fd);
            // comment and blank lines do not yield all six fields
            if (n > 0)
            begin
               fields = $sscanf(text, "%s %h %h %h %h %h", name, opv, a, sz, wd, ex);
               if (fields == 6)
               begin
                  run_access(name, cache_op_t'(opv[0]), a, sz, wd, ex);
                  cases_run++;
               end
            end
         end
         $fclose(fd);
      end

      if (cases_run == 0)
      begin
         $display("no access was run, the case file held no usable line");
         tb_errors++;
      end

      repeat (4) @(negedge CLK);
      assert_fails = dut.u_controller.u_asserts.fail_count;
      $display({"closing: %0d cases, %0d checker errors, %0d testbench errors, ",
                "%0d assertion failures"},
               cases_run, checker_errors, tb_errors, assert_fails);
      if (checker_errors + tb_errors + assert_fails == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
